// ==== seq_game_defines.svh ====
`ifndef SEQ_GAME_DEFINES_SVH
`define SEQ_GAME_DEFINES_SVH

// Length of the stored sequence, which is also the number of rounds.
// The ROM address is 4 bits wide, so this value must not exceed 16.
`define SEQ_LEN 16

// Clock cycles spent waiting for a press before the game is lost.
`define TIMEOUT_CYCLES 200

`endif

// ==== seq_game_pkg.sv ====
package seq_game_pkg;

    typedef logic [3:0] button_t;  // Button set or one-hot play value.
    typedef logic [3:0] addr_t;    // ROM address or round limit.
    typedef logic [3:0] nibble_t;  // Value shown on one display.
    typedef logic [6:0] seg_t;     // Active-low segments, bit 0 is a and bit 6 is g.

    // The encodings are what db_estado shows, so they are fixed here.
    typedef enum logic [3:0] {
        st_idle       = 4'd0,
        st_init_game  = 4'd1,
        st_init_round = 4'd2,
        st_wait_play  = 4'd3,
        st_register   = 4'd4,
        st_compare    = 4'd5,
        st_next_play  = 4'd6,
        st_next_round = 4'd7,
        st_won        = 4'd8,
        st_lost       = 4'd9
    } game_state_t;

endpackage

// ==== seq_rom.sv ====
`timescale 1ns/1ns

module seq_rom (
    input  seq_game_pkg::addr_t   addr,
    output seq_game_pkg::button_t data
);

    // Entry a has bit (a + a/4) mod 4 set, so each quarter starts one bit later.
    always_comb begin
        case (addr)
            4'd0:  data = 4'b0001;
            4'd1:  data = 4'b0010;
            4'd2:  data = 4'b0100;
            4'd3:  data = 4'b1000;
            4'd4:  data = 4'b0010;  // Second quarter starts on bit 1.
            4'd5:  data = 4'b0100;
            4'd6:  data = 4'b1000;
            4'd7:  data = 4'b0001;
            4'd8:  data = 4'b0100;  // Third quarter starts on bit 2.
            4'd9:  data = 4'b1000;
            4'd10: data = 4'b0001;
            4'd11: data = 4'b0010;
            4'd12: data = 4'b1000;  // Last quarter starts on bit 3.
            4'd13: data = 4'b0001;
            4'd14: data = 4'b0010;
            4'd15: data = 4'b0100;
            default: data = 4'b0001;
        endcase
    end

endmodule

// ==== play_detector.sv ====
`timescale 1ns/1ns

module play_detector (
    input  logic                  clock,
    input  logic                  rst_n,
    input  seq_game_pkg::button_t buttons,
    output logic                  play_strobe,
    output seq_game_pkg::button_t pressed
);

    seq_game_pkg::button_t buttons_q;
    logic                  new_press;

    // A press only counts when the buttons leave the all-released state.
    assign new_press = (buttons != '0) && (buttons_q == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            buttons_q   <= '0;
            play_strobe <= 1'b0;
        end else begin
            buttons_q   <= buttons;    // Previous sample for edge detection.
            play_strobe <= new_press;  // One cycle per press, held buttons add none.
        end
    end

    // The pressed value stays until the next press.
    always_ff @(posedge clock) begin
        if (new_press) begin
            pressed <= buttons;
        end
    end

endmodule

// ==== round_datapath.sv ====
`timescale 1ns/1ns
`include "seq_game_defines.svh"

module round_datapath (
    input  logic                  clock,
    input  logic                  rst_n,
    input  seq_game_pkg::button_t buttons,
    input  logic                  addr_clear,
    input  logic                  addr_inc,
    input  logic                  limit_clear,
    input  logic                  limit_inc,
    input  logic                  play_clear,
    input  logic                  play_load,
    input  logic                  timer_clear,
    output logic                  play_strobe,
    output logic                  play_match,
    output logic                  addr_at_limit,
    output logic                  limit_at_end,
    output logic                  timeout,
    output seq_game_pkg::addr_t   addr,
    output seq_game_pkg::addr_t   limit,
    output seq_game_pkg::button_t rom_data,
    output seq_game_pkg::button_t play
);

    localparam int TIMER_W = $clog2(`TIMEOUT_CYCLES + 1);

    seq_game_pkg::button_t pressed;
    logic [TIMER_W-1:0]    timer_count;
    logic                  timer_hit;
    logic                  timed_out;

    seq_rom u_rom (
        .addr (addr),
        .data (rom_data)
    );

    play_detector u_detector (
        .clock       (clock),
        .rst_n       (rst_n),
        .buttons     (buttons),
        .play_strobe (play_strobe),
        .pressed     (pressed)
    );

    // Position inside the current round.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (addr_clear) begin
            addr <= '0;
        end else if (addr_inc) begin
            addr <= addr + 1'b1;
        end
    end

    // Last position of the current round, one less than the round length.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            limit <= '0;
        end else if (limit_clear) begin
            limit <= '0;
        end else if (limit_inc) begin
            limit <= limit + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            play <= '0;
        end else if (play_clear) begin
            play <= '0;
        end else if (play_load) begin
            play <= pressed;  // Takes the value caught by the detector.
        end
    end

    // Runs only while the clear is released and stops at the limit.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            timer_count <= '0;
        end else if (timer_clear) begin
            timer_count <= '0;
        end else if (!timer_hit) begin
            timer_count <= timer_count + 1'b1;
        end
    end

    assign timer_hit = (timer_count == TIMER_W'(`TIMEOUT_CYCLES));

    // The timer is cleared once the game is lost, so this flag keeps the
    // timeout visible until a new game begins.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            timed_out <= 1'b0;
        end else if (limit_clear) begin
            timed_out <= 1'b0;
        end else if (timer_hit) begin
            timed_out <= 1'b1;
        end
    end

    assign timeout       = timer_hit | timed_out;
    assign play_match    = (play == rom_data);
    assign addr_at_limit = (addr == limit);
    assign limit_at_end  = (limit == seq_game_pkg::addr_t'(`SEQ_LEN - 1));

endmodule

// ==== round_controller.sv ====
`timescale 1ns/1ns

module round_controller (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      play_strobe,
    input  logic                      play_match,
    input  logic                      addr_at_limit,
    input  logic                      limit_at_end,
    input  logic                      timeout,
    output logic                      addr_clear,
    output logic                      addr_inc,
    output logic                      limit_clear,
    output logic                      limit_inc,
    output logic                      play_clear,
    output logic                      play_load,
    output logic                      timer_clear,
    output logic                      won,
    output logic                      lost,
    output logic                      done,
    output seq_game_pkg::game_state_t state
);

    seq_game_pkg::game_state_t next_state;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= seq_game_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            seq_game_pkg::st_idle: begin
                if (start) begin
                    next_state = seq_game_pkg::st_init_game;
                end
            end
            seq_game_pkg::st_init_game: begin
                next_state = seq_game_pkg::st_init_round;
            end
            seq_game_pkg::st_init_round: begin
                next_state = seq_game_pkg::st_wait_play;
            end
            seq_game_pkg::st_wait_play: begin
                if (play_strobe) begin
                    next_state = seq_game_pkg::st_register;  // A press wins over a late timeout.
                end else if (timeout) begin
                    next_state = seq_game_pkg::st_lost;
                end
            end
            seq_game_pkg::st_register: begin
                next_state = seq_game_pkg::st_compare;
            end
            seq_game_pkg::st_compare: begin
                if (!play_match) begin
                    next_state = seq_game_pkg::st_lost;
                end else if (!addr_at_limit) begin
                    next_state = seq_game_pkg::st_next_play;
                end else if (limit_at_end) begin
                    next_state = seq_game_pkg::st_won;  // Last play of the last round.
                end else begin
                    next_state = seq_game_pkg::st_next_round;
                end
            end
            seq_game_pkg::st_next_play: begin
                next_state = seq_game_pkg::st_wait_play;
            end
            seq_game_pkg::st_next_round: begin
                next_state = seq_game_pkg::st_init_round;
            end
            seq_game_pkg::st_won, seq_game_pkg::st_lost: begin
                if (start) begin
                    next_state = seq_game_pkg::st_init_game;
                end
            end
            default: begin
                next_state = seq_game_pkg::st_idle;
            end
        endcase
    end

    // Moore outputs, decoded from the registered state only.
    always_comb begin
        addr_clear  = 1'b0;
        addr_inc    = 1'b0;
        limit_clear = 1'b0;
        limit_inc   = 1'b0;
        play_clear  = 1'b0;
        play_load   = 1'b0;
        timer_clear = 1'b1;  // The timer only runs while waiting for a press.
        won         = 1'b0;
        lost        = 1'b0;
        case (state)
            seq_game_pkg::st_init_game:  limit_clear = 1'b1;
            seq_game_pkg::st_init_round: begin
                addr_clear = 1'b1;
                play_clear = 1'b1;
            end
            seq_game_pkg::st_wait_play:  timer_clear = 1'b0;
            seq_game_pkg::st_register:   play_load   = 1'b1;
            seq_game_pkg::st_next_play:  addr_inc    = 1'b1;
            seq_game_pkg::st_next_round: limit_inc   = 1'b1;
            seq_game_pkg::st_won:        won         = 1'b1;
            seq_game_pkg::st_lost:       lost        = 1'b1;
            default: begin
            end
        endcase
    end

    assign done = won | lost;  // Either end of a game.

endmodule

// ==== hex_to_7seg.sv ====
`timescale 1ns/1ns

module hex_to_7seg (
    input  seq_game_pkg::nibble_t value,
    output seq_game_pkg::seg_t    segments
);

    // Patterns are listed as gfedcba, and a zero lights a segment.
    always_comb begin
        case (value)
            4'h0: segments = 7'b100_0000;
            4'h1: segments = 7'b111_1001;
            4'h2: segments = 7'b010_0100;
            4'h3: segments = 7'b011_0000;
            4'h4: segments = 7'b001_1001;
            4'h5: segments = 7'b001_0010;
            4'h6: segments = 7'b000_0010;
            4'h7: segments = 7'b111_1000;
            4'h8: segments = 7'b000_0000;
            4'h9: segments = 7'b001_0000;
            4'ha: segments = 7'b000_1000;
            4'hb: segments = 7'b000_0011;  // Lower case b, to tell it from 8.
            4'hc: segments = 7'b100_0110;
            4'hd: segments = 7'b010_0001;  // Lower case d, to tell it from 0.
            4'he: segments = 7'b000_0110;
            4'hf: segments = 7'b000_1110;
            default: segments = 7'b111_1111;
        endcase
    end

endmodule

// ==== seq_game.sv ====
`timescale 1ns/1ns

module seq_game (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  start,
    input  seq_game_pkg::button_t buttons,
    output logic                  won,
    output logic                  lost,
    output logic                  done,
    output seq_game_pkg::button_t leds,
    output logic                  db_timeout,
    output seq_game_pkg::seg_t    db_contagem,
    output seq_game_pkg::seg_t    db_memoria,
    output seq_game_pkg::seg_t    db_jogadafeita,
    output seq_game_pkg::seg_t    db_sequencia,
    output seq_game_pkg::seg_t    db_estado
);

    logic addr_clear;
    logic addr_inc;
    logic limit_clear;
    logic limit_inc;
    logic play_clear;
    logic play_load;
    logic timer_clear;
    logic play_strobe;
    logic play_match;
    logic addr_at_limit;
    logic limit_at_end;
    logic timeout;

    seq_game_pkg::addr_t       addr;
    seq_game_pkg::addr_t       limit;
    seq_game_pkg::button_t     rom_data;
    seq_game_pkg::button_t     play;
    seq_game_pkg::game_state_t state;
    seq_game_pkg::nibble_t     state_value;

    round_datapath u_datapath (
        .clock         (clock),
        .rst_n         (rst_n),
        .buttons       (buttons),
        .addr_clear    (addr_clear),
        .addr_inc      (addr_inc),
        .limit_clear   (limit_clear),
        .limit_inc     (limit_inc),
        .play_clear    (play_clear),
        .play_load     (play_load),
        .timer_clear   (timer_clear),
        .play_strobe   (play_strobe),
        .play_match    (play_match),
        .addr_at_limit (addr_at_limit),
        .limit_at_end  (limit_at_end),
        .timeout       (timeout),
        .addr          (addr),
        .limit         (limit),
        .rom_data      (rom_data),
        .play          (play)
    );

    round_controller u_controller (
        .clock         (clock),
        .rst_n         (rst_n),
        .start         (start),
        .play_strobe   (play_strobe),
        .play_match    (play_match),
        .addr_at_limit (addr_at_limit),
        .limit_at_end  (limit_at_end),
        .timeout       (timeout),
        .addr_clear    (addr_clear),
        .addr_inc      (addr_inc),
        .limit_clear   (limit_clear),
        .limit_inc     (limit_inc),
        .play_clear    (play_clear),
        .play_load     (play_load),
        .timer_clear   (timer_clear),
        .won           (won),
        .lost          (lost),
        .done          (done),
        .state         (state)
    );

    assign state_value = seq_game_pkg::nibble_t'(state);  // The state code is shown as a digit.
    assign leds        = play;
    assign db_timeout  = timeout;

    hex_to_7seg u_disp_addr  (.value(addr),        .segments(db_contagem));
    hex_to_7seg u_disp_rom   (.value(rom_data),    .segments(db_memoria));
    hex_to_7seg u_disp_play  (.value(play),        .segments(db_jogadafeita));
    hex_to_7seg u_disp_limit (.value(limit),       .segments(db_sequencia));
    hex_to_7seg u_disp_state (.value(state_value), .segments(db_estado));

endmodule

// ==== tb_seq_game.sv ====
`timescale 1ns/1ns
`include "seq_game_defines.svh"

module tb_seq_game;

    // Two games of up to 136 presses at under ten cycles each, plus the timeout wait.
    localparam int MAX_CYCLES = 20000;

    // Lit segments of each hex digit as gfedcba, active high.
    localparam logic [6:0] LIT_SEGMENTS [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic                  clock;
    logic                  rst_n;
    logic                  start;
    seq_game_pkg::button_t buttons;
    logic                  won;
    logic                  lost;
    logic                  done;
    seq_game_pkg::button_t leds;
    logic                  db_timeout;
    seq_game_pkg::seg_t    db_contagem;
    seq_game_pkg::seg_t    db_memoria;
    seq_game_pkg::seg_t    db_jogadafeita;
    seq_game_pkg::seg_t    db_sequencia;
    seq_game_pkg::seg_t    db_estado;
    logic [6:0]            expected_memoria;
    logic                  in_won;
    logic                  in_lost;
    logic [31:0]           seed;
    int                    cycle_count;
    int                    test_errors;
    int                    pass_count;
    int                    fail_count;

    seq_game dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .start          (start),
        .buttons        (buttons),
        .won            (won),
        .lost           (lost),
        .done           (done),
        .leds           (leds),
        .db_timeout     (db_timeout),
        .db_contagem    (db_contagem),
        .db_memoria     (db_memoria),
        .db_jogadafeita (db_jogadafeita),
        .db_sequencia   (db_sequencia),
        .db_estado      (db_estado)
    );

    always #5 clock = ~clock;

    function automatic logic [6:0] glyph(input logic [3:0] v);
        return ~LIT_SEGMENTS[v];  // The displays light a segment with a zero.
    endfunction

    function automatic logic [3:0] rom_value(input int a);
        return 4'b0001 << ((a + a / 4) % 4);
    endfunction

    function automatic int digit_of(input logic [6:0] segments);
        int found;
        int d;
        found = 0;
        for (d = 0; d < 16; d++) begin
            if (glyph(4'(d)) == segments) begin
                found = d;
            end
        end
        return found;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // The ROM display must follow whatever address the counter display shows.
    always_comb expected_memoria = glyph(rom_value(digit_of(db_contagem)));

    // The end flags follow the state shown on the state display.
    always_comb in_won = (db_estado == glyph(4'd8));
    always_comb in_lost = (db_estado == glyph(4'd9));

    memoria_follows_address: assert property (@(posedge clock) disable iff (!rst_n)
        db_memoria == expected_memoria)
    else begin
        $display("Error at %0t ns: db_memoria expected %h, got %h",
                 $time, $sampled(expected_memoria), $sampled(db_memoria));
        test_errors++;
    end

    won_only_in_won: assert property (@(posedge clock) disable iff (!rst_n)
        won == in_won)
    else begin
        $display("Error at %0t ns: won expected %b, got %b",
                 $time, $sampled(in_won), $sampled(won));
        test_errors++;
    end

    lost_only_in_lost: assert property (@(posedge clock) disable iff (!rst_n)
        lost == in_lost)
    else begin
        $display("Error at %0t ns: lost expected %b, got %b",
                 $time, $sampled(in_lost), $sampled(lost));
        test_errors++;
    end

    done_is_end_of_game: assert property (@(posedge clock) disable iff (!rst_n)
        done == (in_won || in_lost))
    else begin
        $display("Error at %0t ns: done expected %b, got %b",
                 $time, $sampled(in_won || in_lost), $sampled(done));
        test_errors++;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("The run stopped at the cycle limit before all tests finished.");
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [6:0] expected,
                               input logic [6:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %s: passed", name);
        end else begin
            fail_count++;
            $display("Test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic start_game();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // Returns once the game waits for a press, or gives up if it ended.
    task automatic wait_ready(output bit ok);
        int waited;
        waited = 0;
        while (db_estado != glyph(4'd3) && !done && waited < 50) begin
            @(negedge clock);
            waited++;
        end
        ok = (db_estado == glyph(4'd3));
        assert (ok) else begin
            $display("At %0t ns the game did not come back to wait for a press.", $time);
            test_errors++;
        end
    endtask

    task automatic press(input logic [3:0] value);
        buttons = value;
        repeat (2) @(negedge clock);
        buttons = '0;
        repeat (2) @(negedge clock);
    endtask

    // Register and compare take a few cycles, so the verdict is a later state.
    task automatic wait_verdict();
        int waited;
        waited = 0;
        while ((db_estado == glyph(4'd3) || db_estado == glyph(4'd4) ||
                db_estado == glyph(4'd5)) && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        assert (waited < 20) else begin
            $display("At %0t ns a press got no verdict from the game.", $time);
            test_errors++;
        end
    endtask

    task automatic play_rounds(input int count, output bit ok);
        int r;
        int p;
        ok = 1'b1;
        for (r = 0; r < count && ok; r++) begin
            for (p = 0; p <= r && ok; p++) begin
                wait_ready(ok);
                if (ok) begin
                    check_value("db_sequencia", glyph(4'(r)), db_sequencia);
                    press(rom_value(p));
                    wait_verdict();
                end
            end
        end
    endtask

    task automatic test_wrong_press();
        int         round_sel;
        int         pos;
        int         p;
        bit         ok;
        logic [3:0] wrong;
        seed = xorshift(seed);
        round_sel = int'(seed % `SEQ_LEN);
        seed = xorshift(seed);
        pos = int'(seed % 32'(round_sel + 1));
        do begin
            seed = xorshift(seed);
            wrong = seed[3:0];
        end while (wrong == '0 || wrong == rom_value(pos));
        $display("Wrong press %h in round %0d at position %0d", wrong, round_sel, pos);
        start_game();
        play_rounds(round_sel, ok);
        for (p = 0; p < pos && ok; p++) begin
            wait_ready(ok);
            press(rom_value(p));
            wait_verdict();
        end
        wait_ready(ok);
        press(wrong);
        wait_verdict();
        check_value("lost", 7'd1, 7'(lost));
        check_value("done", 7'd1, 7'(done));
        check_value("won", 7'd0, 7'(won));
        check_value("leds", 7'(wrong), 7'(leds));
        check_value("db_jogadafeita", glyph(wrong), db_jogadafeita);
        check_value("db_estado", glyph(4'd9), db_estado);
    endtask

    initial begin
        bit ok;
        clock = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        buttons = '0;
        seed = 32'hc228;
        cycle_count = 0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (4) @(negedge clock);
        rst_n = 1'b1;

        check_value("won", 7'd0, 7'(won));
        check_value("lost", 7'd0, 7'(lost));
        check_value("done", 7'd0, 7'(done));
        check_value("db_timeout", 7'd0, 7'(db_timeout));
        check_value("db_estado", glyph(4'd0), db_estado);
        check_value("db_contagem", glyph(4'd0), db_contagem);
        check_value("db_sequencia", glyph(4'd0), db_sequencia);
        check_value("db_jogadafeita", glyph(4'd0), db_jogadafeita);
        finish_test("reset");

        start_game();
        play_rounds(`SEQ_LEN, ok);
        check_value("won", 7'd1, 7'(won));
        check_value("done", 7'd1, 7'(done));
        check_value("lost", 7'd0, 7'(lost));
        check_value("db_estado", glyph(4'd8), db_estado);
        finish_test("full_game");

        test_wrong_press();
        finish_test("wrong_press");

        start_game();
        wait_ready(ok);
        repeat (`TIMEOUT_CYCLES - 10) @(negedge clock);
        check_value("lost", 7'd0, 7'(lost));  // Still waiting shortly before the limit.
        repeat (20) @(negedge clock);
        check_value("lost", 7'd1, 7'(lost));
        check_value("db_timeout", 7'd1, 7'(db_timeout));
        finish_test("timeout");

        start_game();
        wait_ready(ok);
        check_value("done", 7'd0, 7'(done));
        check_value("lost", 7'd0, 7'(lost));
        check_value("db_timeout", 7'd0, 7'(db_timeout));
        check_value("db_sequencia", glyph(4'd0), db_sequencia);
        buttons = rom_value(0);  // Held long enough to span a whole round.
        repeat (20) @(negedge clock);
        buttons = '0;
        repeat (2) @(negedge clock);
        wait_ready(ok);
        check_value("db_sequencia", glyph(4'd1), db_sequencia);
        check_value("db_contagem", glyph(4'd0), db_contagem);
        press(rom_value(0));
        wait_verdict();
        wait_ready(ok);
        press(rom_value(1));
        wait_verdict();
        wait_ready(ok);
        check_value("lost", 7'd0, 7'(lost));
        check_value("db_sequencia", glyph(4'd2), db_sequencia);
        finish_test("restart_and_hold");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== seq_game.f ====
+incdir+.
seq_game_pkg.sv
seq_rom.sv
play_detector.sv
round_datapath.sv
round_controller.sv
hex_to_7seg.sv
seq_game.sv
tb_seq_game.sv

// ==== Makefile ====
# Verilator build and run for the sequence game testbench.
# Any variable can be overridden, for example: make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_seq_game
FILELIST  ?= seq_game.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
